/* all.f */
source/nn_num_pkg.sv
source/nn_seq_pkg.sv
source/sample_loader.sv
source/weight_loader.sv
source/forward_engine.sv
source/nn_top.sv
test/clock_gen.sv
test/nn_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module nn_tb -o nn_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/nn_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* test/nn_tb.sv */
`timescale 1ns/1ps

module nn_tb
    import nn_num_pkg::*;
();

    localparam int LATENCY        = 10;  // Rising edges from fourth word to out_valid
    localparam int TIMEOUT_CYCLES = 40;

    logic      clk;
    logic      rst_n;
    logic      in_valid_d;
    logic      in_valid_w1;
    logic      in_valid_w2;
    fix_word_u data_point;
    fix_word_u weight1;
    fix_word_u weight2;
    logic      out_valid;
    fix_word_u out;

    integer seed;
    logic signed [WORD_BITS-1:0] ref_w1 [HIDDEN][INPUTS];  // Model copy of the weights
    logic signed [WORD_BITS-1:0] ref_w2 [HIDDEN];
    logic signed [WORD_BITS-1:0] x [INPUTS];               // Current sample

    clock_gen clock_gen_i (.clk(clk));

    nn_top nn_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_d  (in_valid_d),
        .in_valid_w1 (in_valid_w1),
        .in_valid_w2 (in_valid_w2),
        .data_point  (data_point),
        .weight1     (weight1),
        .weight2     (weight2),
        .out_valid   (out_valid),
        .out         (out)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Full product, shift right by the fraction, keep one word
    function automatic logic signed [WORD_BITS-1:0] fixed_product(
        input logic signed [WORD_BITS-1:0] a,
        input logic signed [WORD_BITS-1:0] b
    );
        logic signed [2*WORD_BITS-1:0] p;
        p = a * b;
        return p[FRAC_BITS +: WORD_BITS];
    endfunction

    function automatic logic signed [WORD_BITS-1:0] model_out();
        logic signed [WORD_BITS-1:0] h;
        logic signed [WORD_BITS-1:0] y;
        y = '0;
        for (int j = 0; j < HIDDEN; j++) begin
            h = '0;
            for (int k = 0; k < INPUTS; k++) begin
                h = h + fixed_product(x[k], ref_w1[j][k]);  // Wraps in one word
            end
            if (h < 16'sd0) begin
                h = '0;  // ReLU
            end
            y = y + fixed_product(h, ref_w2[j]);
        end
        return y;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic random_sample();
        for (int k = 0; k < INPUTS; k++) x[k] = 16'($random(seed) % 2048);
    endtask

    task automatic positive_sample();
        for (int k = 0; k < INPUTS; k++) x[k] = 16'(($random(seed) & 255) + 1);
    endtask

    task automatic random_weights();
        for (int j = 0; j < HIDDEN; j++) begin
            for (int k = 0; k < INPUTS; k++) ref_w1[j][k] = 16'($random(seed) % 256);
            ref_w2[j] = 16'($random(seed) % 256);
        end
    endtask

    // Rows of w1 all negative, except pos_row when it names a neuron
    task automatic clipping_weights(input int pos_row);
        for (int j = 0; j < HIDDEN; j++) begin
            for (int k = 0; k < INPUTS; k++) begin
                if (j == pos_row) ref_w1[j][k] = 16'(($random(seed) & 255) + 1);
                else ref_w1[j][k] = 16'(-(($random(seed) & 255) + 1));
            end
        end
    endtask

    // Row order, first word ends in row 0 column 0
    task automatic load_weights();
        for (int j = 0; j < HIDDEN; j++) begin
            for (int k = 0; k < INPUTS; k++) begin
                @(negedge clk);
                in_valid_w1   = 1'b1;
                weight1.value = ref_w1[j][k];
            end
        end
        @(negedge clk);
        in_valid_w1 = 1'b0;
        for (int j = 0; j < HIDDEN; j++) begin
            @(negedge clk);
            in_valid_w2   = 1'b1;
            weight2.value = ref_w2[j];
        end
        @(negedge clk);
        in_valid_w2 = 1'b0;
    endtask

    // Send one sample, wait for the pulse and check result and latency
    task automatic run_sample(input logic signed [WORD_BITS-1:0] expected);
        int   edges;
        logic seen;
        for (int k = 0; k < INPUTS; k++) begin
            @(negedge clk);
            in_valid_d       = 1'b1;
            data_point.value = x[k];
        end
        @(negedge clk);  // Fourth word captured on the edge just passed
        in_valid_d = 1'b0;
        data_point = '0;
        edges      = 0;
        seen       = 1'b0;
        while (!seen && edges < TIMEOUT_CYCLES) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (out_valid) seen = 1'b1;
            else check_value("out", 0, int'(out.value));
        end
        assert (seen) else begin
            $display("timeout: out_valid did not rise within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        check_value("out_valid latency", LATENCY, edges);
        check_value("out", int'(expected), int'(out.value));
        @(negedge clk);
        check_value("out_valid", 0, int'(out_valid));  // Pulse is one cycle
        check_value("out", 0, int'(out.value));
    endtask

    initial begin
        seed        = 26;
        rst_n       = 1'b0;
        in_valid_d  = 1'b0;
        in_valid_w1 = 1'b0;
        in_valid_w2 = 1'b0;
        data_point  = '0;
        weight1     = '0;
        weight2     = '0;
        for (int j = 0; j < HIDDEN; j++) begin
            for (int k = 0; k < INPUTS; k++) ref_w1[j][k] = '0;
            ref_w2[j] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", 0, int'(out_valid));
        check_value("out", 0, int'(out.value));

        // Weights still zero from reset
        random_sample();
        run_sample(16'sd0);

        random_weights();
        load_weights();
        repeat (30) begin
            random_sample();
            run_sample(model_out());
        end

        // ReLU clipping, then one live neuron
        clipping_weights(-1);
        load_weights();
        repeat (4) begin
            positive_sample();
            run_sample(16'sd0);
        end
        clipping_weights(1);
        load_weights();
        repeat (4) begin
            positive_sample();
            run_sample(model_out());
        end

        // Reload both sets
        random_weights();
        load_weights();
        repeat (10) begin
            random_sample();
            run_sample(model_out());
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

/* source/nn_top.sv */
`timescale 1ns/1ps

module nn_top import nn_num_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid_d,
    input  logic      in_valid_w1,
    input  logic      in_valid_w2,
    input  fix_word_u data_point,
    input  fix_word_u weight1,
    input  fix_word_u weight2,
    output logic      out_valid,
    output fix_word_u out
);

    fix_word_u sample [INPUTS];
    logic      sample_ready;
    fix_word_u w1 [HIDDEN][INPUTS];
    fix_word_u w2 [HIDDEN];

    // Both loaders run side by side
    sample_loader sample_loader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_d   (in_valid_d),
        .data_point   (data_point),
        .sample       (sample),
        .sample_ready (sample_ready)
    );

    weight_loader weight_loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_w1 (in_valid_w1),
        .weight1     (weight1),
        .in_valid_w2 (in_valid_w2),
        .weight2     (weight2),
        .w1          (w1),
        .w2          (w2)
    );

    forward_engine forward_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_ready (sample_ready),
        .w1           (w1),
        .w2           (w2),
        .out_valid    (out_valid),
        .out          (out)
    );

endmodule

/* source/forward_engine.sv */
`timescale 1ns/1ps

module forward_engine
    import nn_num_pkg::*;
    import nn_seq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  fix_word_u sample [INPUTS],
    input  logic      sample_ready,
    input  fix_word_u w1 [HIDDEN][INPUTS],
    input  fix_word_u w2 [HIDDEN],
    output logic      out_valid,
    output fix_word_u out
);

    logic [STATE_BITS-1:0] state;
    logic [STEP_BITS-1:0]  step;  // Input index, then hidden index

    fix_word_u acc [HIDDEN];  // Hidden neuron sums
    fix_word_u act [HIDDEN];  // After ReLU
    fix_word_u out_acc;

    // Fixed point product, truncated back to one word
    function automatic logic signed [WORD_BITS-1:0] fix_mul(
        input logic signed [WORD_BITS-1:0] a,
        input logic signed [WORD_BITS-1:0] b
    );
        logic signed [2*WORD_BITS-1:0] prod;
        prod    = a * b;
        fix_mul = WORD_BITS'(prod >>> FRAC_BITS);
    endfunction

    // Negative sums clip to zero
    function automatic fix_word_u relu(input fix_word_u h);
        fix_word_u r;
        r = h;
        if (h.fields.sign) begin
            r = '0;
        end
        return r;
    endfunction

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            step  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sample_ready) begin
                        state <= ST_HIDDEN;
                        step  <= '0;
                    end
                end
                ST_HIDDEN: begin
                    if (step == HIDDEN_LAST_STEP) begin
                        state <= ST_RELU;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                ST_RELU: state <= ST_OUTPUT;
                ST_OUTPUT: begin
                    if (step == OUTPUT_LAST_STEP) begin
                        state <= ST_DONE;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                ST_DONE: state <= ST_IDLE;  // One cycle only
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (sample_ready) begin  // Fresh sums for a new sample
                    for (int j = 0; j < HIDDEN; j++) begin
                        acc[j] <= '0;
                    end
                    out_acc <= '0;
                end
            end
            ST_HIDDEN: begin
                // All three neurons take input word step together
                for (int j = 0; j < HIDDEN; j++) begin
                    acc[j].value <= acc[j].value
                                  + fix_mul(sample[step].value, w1[j][step].value);
                end
            end
            ST_RELU: begin
                for (int j = 0; j < HIDDEN; j++) begin
                    act[j] <= relu(acc[j]);
                end
            end
            ST_OUTPUT: begin
                out_acc.value <= out_acc.value + fix_mul(act[step].value, w2[step].value);
            end
            default: ;
        endcase
    end

    // Result register, zero outside the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else if (state == ST_DONE) begin
            out_valid <= 1'b1;
            out       <= out_acc;
        end else begin
            out_valid <= 1'b0;
            out       <= '0;
        end
    end

    out_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    );
    out_idle_zero_a: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> (out.value == '0)
    );

endmodule

/* source/weight_loader.sv */
`timescale 1ns/1ps

module weight_loader import nn_num_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid_w1,
    input  fix_word_u weight1,
    input  logic      in_valid_w2,
    input  fix_word_u weight2,
    output fix_word_u w1 [HIDDEN][INPUTS],
    output fix_word_u w2 [HIDDEN]
);

    ////////////////////////////////
    // First layer, twelve word chain
    ////////////////////////////////

    // Row 0 column 0 is the head, new words enter at row 2 column 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < HIDDEN; j++) begin
                for (int k = 0; k < INPUTS; k++) begin
                    w1[j][k] <= '0;
                end
            end
        end else if (in_valid_w1) begin
            for (int j = 0; j < HIDDEN; j++) begin
                for (int k = 0; k < INPUTS - 1; k++) begin
                    w1[j][k] <= w1[j][k+1];
                end
                // Last column pulls from the start of the next row
                if (j < HIDDEN - 1) begin
                    w1[j][INPUTS-1] <= w1[j+1][0];
                end
            end
            w1[HIDDEN-1][INPUTS-1] <= weight1;
        end
    end

    ////////////////////////////////
    // Second layer, three word chain
    ////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < HIDDEN; j++) begin
                w2[j] <= '0;
            end
        end else if (in_valid_w2) begin
            for (int j = 0; j < HIDDEN - 1; j++) begin
                w2[j] <= w2[j+1];
            end
            w2[HIDDEN-1] <= weight2;  // Newest word
        end
    end

    // Weight sets are loaded one at a time
    one_chain_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(in_valid_w1 && in_valid_w2)
    );

endmodule

/* source/sample_loader.sv */
`timescale 1ns/1ps

module sample_loader import nn_num_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid_d,
    input  fix_word_u data_point,
    output fix_word_u sample [INPUTS],
    output logic      sample_ready
);

    logic [INPUT_IDX_BITS-1:0] count;  // Words of the current sample

    // Shift register, oldest word ends in position 0
    always_ff @(posedge clk) begin
        if (in_valid_d) begin
            for (int i = 0; i < INPUTS - 1; i++) begin
                sample[i] <= sample[i+1];
            end
            sample[INPUTS-1] <= data_point;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count        <= '0;
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= 1'b0;
            if (in_valid_d) begin
                if (count == INPUT_IDX_BITS'(INPUTS - 1)) begin
                    count        <= '0;
                    sample_ready <= 1'b1;  // Fourth word captured
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // Ready is a pulse, never a level
    ready_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) sample_ready |=> !sample_ready
    );

endmodule

/* source/nn_seq_pkg.sv */
package nn_seq_pkg;

    ///////////////////////////////
    // Forward engine FSM
    ///////////////////////////////

    localparam int STATE_BITS = 3;
    localparam int STEP_BITS  = 2;

    localparam logic [STATE_BITS-1:0] ST_IDLE   = 3'd0;  // Waiting for a full sample
    localparam logic [STATE_BITS-1:0] ST_HIDDEN = 3'd1;  // Hidden layer MACs
    localparam logic [STATE_BITS-1:0] ST_RELU   = 3'd2;
    localparam logic [STATE_BITS-1:0] ST_OUTPUT = 3'd3;  // Output neuron MACs
    localparam logic [STATE_BITS-1:0] ST_DONE   = 3'd4;  // Result pulse

    // Last step of each MAC stage
    // Hidden stage walks the four inputs
    localparam logic [STEP_BITS-1:0] HIDDEN_LAST_STEP = 2'd3;
    // Output stage walks the three hidden neurons
    localparam logic [STEP_BITS-1:0] OUTPUT_LAST_STEP = 2'd2;

endpackage

/* source/nn_num_pkg.sv */
package nn_num_pkg;

    // Signed fixed point, 16-bit words with 8 fraction bits
    localparam int WORD_BITS = 16;
    localparam int FRAC_BITS = 8;

    // Layer sizes
    localparam int INPUTS = 4;
    localparam int HIDDEN = 3;
    localparam int INPUT_IDX_BITS = $clog2(INPUTS);  // Word counter of the sample loader

    ///////////////////////////////
    // Arithmetic rule
    // A product is the full 32-bit signed product, shifted right arithmetically
    // by FRAC_BITS and truncated to its low WORD_BITS
    // Sums wrap modulo 2**WORD_BITS
    ///////////////////////////////

    // Sign and magnitude body, used by the ReLU
    typedef struct packed {
        logic                 sign;
        logic [WORD_BITS-2:0] body;
    } fix_fields_s;

    // One data or weight word, read as a number or as its fields
    typedef union packed {
        logic signed [WORD_BITS-1:0] value;  // MAC operand
        fix_fields_s                 fields;
    } fix_word_u;

endpackage
